// File: source/axis_out_pkg.sv
// --------------------
// axis_out shared widths, sizes, register map
// and the fifo word/lane view
// --------------------
`default_nettype none

package axis_out_pkg;

   // bus and stream widths
   localparam int DATA_W  = 32;
   localparam int TDATA_W = 8;
   localparam int LANES   = DATA_W / TDATA_W;

   // fifo geometry, level counted in lanes
   localparam int FIFO_WORDS = 8;
   localparam int LEVEL_W    = 6;
   localparam int WPTR_W     = $clog2(FIFO_WORDS);
   localparam int LANE_W     = $clog2(LANES);
   localparam int RPTR_W     = WPTR_W + LANE_W;
   localparam logic [LEVEL_W-1:0] LEVEL_LANES = LEVEL_W'(LANES);
   localparam logic [LEVEL_W-1:0] FULL_LEVEL  = LEVEL_W'(FIFO_WORDS * LANES - LANES);

   // register map
   localparam int ADDR_W = 3;
   localparam logic [ADDR_W-1:0] ADDR_CTRL      = 3'd0;
   localparam logic [ADDR_W-1:0] ADDR_NWORDS    = 3'd1;
   localparam logic [ADDR_W-1:0] ADDR_THRESHOLD = 3'd2;
   localparam logic [ADDR_W-1:0] ADDR_DATA      = 3'd3;
   localparam logic [ADDR_W-1:0] ADDR_STATUS    = 3'd4;

   localparam int CTRL_ENABLE_BIT   = 0;
   localparam int CTRL_MODE_BIT     = 1;
   localparam int CTRL_SRST_BIT     = 2;
   localparam int STATUS_EMPTY_BIT  = 0;
   localparam int STATUS_FULL_BIT   = 1;
   localparam int STATUS_LEVEL_LSB  = 8;

   // serializer states
   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_SEND = 1'b1;

   // lane 0 is the low byte and goes out first
   typedef union packed {
      logic [DATA_W-1:0]               word;
      logic [LANES-1:0][TDATA_W-1:0]   lane;
   } fifo_word_t;

endpackage

`default_nettype wire

// File: source/axis_out_csr.sv
// --------------------
// axis_out register block: control registers,
// cpu/dma write merge, status and interrupt
// --------------------
`timescale 1ns/1ps
`default_nettype none

module axis_out_csr (
   input  wire                               clk_i,
   input  wire                               reset_i,
   // register bus
   input  wire                               csr_we_i,
   input  wire  [axis_out_pkg::ADDR_W-1:0]   csr_addr_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   csr_wdata_i,
   output logic [axis_out_pkg::DATA_W-1:0]   csr_rdata_o,
   output logic                              csr_ready_o,
   // dma input
   input  wire                               sys_tvalid_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   sys_tdata_i,
   output logic                              sys_tready_o,
   // fifo status
   input  wire                               fifo_empty_i,
   input  wire                               fifo_full_i,
   input  wire  [axis_out_pkg::LEVEL_W-1:0]  fifo_level_i,
   // fifo write side
   output logic                              push_o,
   output logic [axis_out_pkg::DATA_W-1:0]   push_data_o,
   // configuration
   output logic                              soft_reset_o,
   output logic                              enable_o,
   output logic [axis_out_pkg::DATA_W-1:0]   nwords_o,
   output logic                              interrupt_o
);

   logic                              enable_q;
   logic                              mode_q;
   logic                              soft_reset_q;
   logic [axis_out_pkg::DATA_W-1:0]   nwords_q;
   logic [axis_out_pkg::LEVEL_W-1:0]  threshold_q;
   logic                              cpu_push;
   logic                              dma_push;

   // control registers, soft reset bit clears itself
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         enable_q     <= 1'b0;
         mode_q       <= 1'b0;
         soft_reset_q <= 1'b0;
         nwords_q     <= '0;
         threshold_q  <= '0;
      end else begin
         soft_reset_q <= 1'b0;
         if (csr_we_i) begin
            case (csr_addr_i)
               axis_out_pkg::ADDR_CTRL: begin
                  enable_q     <= csr_wdata_i[axis_out_pkg::CTRL_ENABLE_BIT];
                  mode_q       <= csr_wdata_i[axis_out_pkg::CTRL_MODE_BIT];
                  soft_reset_q <= csr_wdata_i[axis_out_pkg::CTRL_SRST_BIT];
               end
               axis_out_pkg::ADDR_NWORDS: begin
                  nwords_q <= csr_wdata_i;
               end
               axis_out_pkg::ADDR_THRESHOLD: begin
                  threshold_q <= csr_wdata_i[axis_out_pkg::LEVEL_W-1:0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // dma accepts only in dma mode with room left
   assign sys_tready_o = enable_q && mode_q && !fifo_full_i;
   assign csr_ready_o  = !fifo_full_i;

   // processor data write, dropped when full, disabled or in dma mode
   assign cpu_push = csr_we_i && (csr_addr_i == axis_out_pkg::ADDR_DATA) &&
                     enable_q && !mode_q && !fifo_full_i;
   assign dma_push = sys_tvalid_i && sys_tready_o;

   assign push_o      = cpu_push || dma_push;
   assign push_data_o = mode_q ? sys_tdata_i : csr_wdata_i;

   assign soft_reset_o = soft_reset_q;
   assign enable_o     = enable_q;
   assign nwords_o     = nwords_q;

   // level at or below threshold
   assign interrupt_o = (fifo_level_i <= threshold_q);

   // read mux
   always_comb begin
      csr_rdata_o = '0;
      case (csr_addr_i)
         axis_out_pkg::ADDR_CTRL: begin
            csr_rdata_o[axis_out_pkg::CTRL_ENABLE_BIT] = enable_q;
            csr_rdata_o[axis_out_pkg::CTRL_MODE_BIT]   = mode_q;
         end
         axis_out_pkg::ADDR_NWORDS: begin
            csr_rdata_o = nwords_q;
         end
         axis_out_pkg::ADDR_THRESHOLD: begin
            csr_rdata_o[axis_out_pkg::LEVEL_W-1:0] = threshold_q;
         end
         axis_out_pkg::ADDR_STATUS: begin
            csr_rdata_o[axis_out_pkg::STATUS_EMPTY_BIT] = fifo_empty_i;
            csr_rdata_o[axis_out_pkg::STATUS_FULL_BIT]  = fifo_full_i;
            csr_rdata_o[axis_out_pkg::STATUS_LEVEL_LSB +: axis_out_pkg::LEVEL_W] =
               fifo_level_i;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/axis_out_fifo.sv
// --------------------
// axis_out fifo: 32-bit words in,
// byte lanes out, level in lanes
// --------------------
`timescale 1ns/1ps
`default_nettype none

module axis_out_fifo (
   input  wire                               clk_i,
   input  wire                               reset_i,
   input  wire                               soft_reset_i,
   // word write side
   input  wire                               push_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   push_data_i,
   // lane read side
   input  wire                               pop_i,
   output logic [axis_out_pkg::TDATA_W-1:0]  pop_data_o,
   // status
   output logic                              empty_o,
   output logic                              full_o,
   output logic [axis_out_pkg::LEVEL_W-1:0]  level_o
);

   axis_out_pkg::fifo_word_t              mem [axis_out_pkg::FIFO_WORDS];
   logic [axis_out_pkg::WPTR_W-1:0]       wr_ptr_q;
   logic [axis_out_pkg::RPTR_W-1:0]       rd_ptr_q;
   logic [axis_out_pkg::LEVEL_W-1:0]      level_q;
   logic [axis_out_pkg::WPTR_W-1:0]       rd_word;
   logic [axis_out_pkg::LANE_W-1:0]       rd_lane;
   logic                                  do_push;
   logic                                  do_pop;

   assign empty_o = (level_q == '0);
   // less than one word of room left
   assign full_o  = (level_q > axis_out_pkg::FULL_LEVEL);
   assign level_o = level_q;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   // read pointer splits into word index and lane
   assign rd_word = rd_ptr_q[axis_out_pkg::RPTR_W-1:axis_out_pkg::LANE_W];
   assign rd_lane = rd_ptr_q[axis_out_pkg::LANE_W-1:0];

   // storage, written a whole word at a time
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q].word <= push_data_i;
      end
   end

   // pointers and lane count
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: level_q <= level_q + axis_out_pkg::LEVEL_LANES;
            2'b01: level_q <= level_q - 1'b1;
            2'b11: level_q <= level_q + axis_out_pkg::LEVEL_LANES - 1'b1;
            default: begin
            end
         endcase
      end
   end

   // popped lane is held until the next pop
   always_ff @(posedge clk_i) begin
      if (do_pop) begin
         pop_data_o <= mem[rd_word].lane[rd_lane];
      end
   end

   // the register block must stop pushing once full
   a_no_push_full: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(push_i && full_o)
   ) else $error("axis_out_fifo: push while full, level %0d", level_q);

   // the serializer must not pop an empty fifo
   a_no_pop_empty: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !(pop_i && empty_o)
   ) else $error("axis_out_fifo: pop while empty");

endmodule

`default_nettype wire

// File: source/axis_out_serializer.sv
// --------------------
// axis_out serializer: pops fifo lanes onto
// the stream, counts bytes, drops padding
// --------------------
`timescale 1ns/1ps
`default_nettype none

module axis_out_serializer (
   input  wire                               clk_i,
   input  wire                               reset_i,
   input  wire                               soft_reset_i,
   // configuration
   input  wire                               enable_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   nwords_i,
   // fifo read side
   input  wire                               fifo_empty_i,
   input  wire  [axis_out_pkg::TDATA_W-1:0]  fifo_data_i,
   output logic                              pop_o,
   // stream output
   input  wire                               axis_tready_i,
   output logic                              axis_tvalid_o,
   output logic [axis_out_pkg::TDATA_W-1:0]  axis_tdata_o,
   output logic                              axis_tlast_o
);

   logic                              state_q;
   logic                              state_d;
   logic [axis_out_pkg::DATA_W-1:0]   count_q;
   logic                              in_frame;

   // count holds the 1-based index of the lane on fifo_data_i
   assign in_frame = (count_q <= nwords_i);

   always_comb begin
      state_d       = state_q;
      pop_o         = 1'b0;
      axis_tvalid_o = 1'b0;
      if (enable_i) begin
         case (state_q)
            axis_out_pkg::ST_IDLE: begin
               if (!fifo_empty_i) begin
                  pop_o   = 1'b1;
                  state_d = axis_out_pkg::ST_SEND;
               end
            end
            default: begin
               if (in_frame) begin
                  axis_tvalid_o = 1'b1;
                  // move on only once the byte is taken
                  if (axis_tready_i) begin
                     if (fifo_empty_i) begin
                        state_d = axis_out_pkg::ST_IDLE;
                     end else begin
                        pop_o = 1'b1;
                     end
                  end
               end else begin
                  // padding, drain without valid
                  if (fifo_empty_i) begin
                     state_d = axis_out_pkg::ST_IDLE;
                  end else begin
                     pop_o = 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // state and byte counter, soft reset starts a new transfer
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         state_q <= axis_out_pkg::ST_IDLE;
         count_q <= '0;
      end else begin
         state_q <= state_d;
         if (pop_o) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   assign axis_tdata_o = fifo_data_i;
   assign axis_tlast_o = (count_q == nwords_i) && axis_tvalid_o;

   // after the last byte is taken, only padding may follow
   a_last_ends_frame: assert property (
      @(posedge clk_i) disable iff (reset_i || soft_reset_i)
      (axis_tvalid_o && axis_tready_i && axis_tlast_o) |=> !axis_tvalid_o
   ) else $error("axis_out_serializer: valid after last, count %0d", count_q);

   // a stalled byte keeps its value
   a_data_stable: assert property (
      @(posedge clk_i) disable iff (reset_i || soft_reset_i)
      (axis_tvalid_o && !axis_tready_i) |=> $stable(axis_tdata_o)
   ) else $error("axis_out_serializer: tdata changed under back-pressure, now 0x%0h",
                 axis_tdata_o);

endmodule

`default_nettype wire

// File: source/axis_out_top.sv
// --------------------
// axis_out top: register block, fifo
// and serializer
// --------------------
`timescale 1ns/1ps
`default_nettype none

module axis_out_top (
   input  wire                               clk_i,
   input  wire                               reset_i,
   // register bus
   input  wire                               csr_we_i,
   input  wire  [axis_out_pkg::ADDR_W-1:0]   csr_addr_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   csr_wdata_i,
   output logic [axis_out_pkg::DATA_W-1:0]   csr_rdata_o,
   output logic                              csr_ready_o,
   // dma input
   input  wire                               sys_tvalid_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   sys_tdata_i,
   output logic                              sys_tready_o,
   // stream output
   output logic                              axis_tvalid_o,
   output logic [axis_out_pkg::TDATA_W-1:0]  axis_tdata_o,
   output logic                              axis_tlast_o,
   input  wire                               axis_tready_i,
   output logic                              interrupt_o
);

   logic                              fifo_push;
   logic [axis_out_pkg::DATA_W-1:0]   fifo_push_data;
   logic                              fifo_pop;
   logic [axis_out_pkg::TDATA_W-1:0]  fifo_data;
   logic                              fifo_empty;
   logic                              fifo_full;
   logic [axis_out_pkg::LEVEL_W-1:0]  fifo_level;
   logic                              soft_reset;
   logic                              enable;
   logic [axis_out_pkg::DATA_W-1:0]   nwords;

   axis_out_csr i_csr (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .csr_we_i     (csr_we_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rdata_o  (csr_rdata_o),
      .csr_ready_o  (csr_ready_o),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .sys_tready_o (sys_tready_o),
      .fifo_empty_i (fifo_empty),
      .fifo_full_i  (fifo_full),
      .fifo_level_i (fifo_level),
      .push_o       (fifo_push),
      .push_data_o  (fifo_push_data),
      .soft_reset_o (soft_reset),
      .enable_o     (enable),
      .nwords_o     (nwords),
      .interrupt_o  (interrupt_o)
   );

   axis_out_fifo i_fifo (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .soft_reset_i (soft_reset),
      .push_i       (fifo_push),
      .push_data_i  (fifo_push_data),
      .pop_i        (fifo_pop),
      .pop_data_o   (fifo_data),
      .empty_o      (fifo_empty),
      .full_o       (fifo_full),
      .level_o      (fifo_level)
   );

   axis_out_serializer i_serializer (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .soft_reset_i  (soft_reset),
      .enable_i      (enable),
      .nwords_i      (nwords),
      .fifo_empty_i  (fifo_empty),
      .fifo_data_i   (fifo_data),
      .pop_o         (fifo_pop),
      .axis_tready_i (axis_tready_i),
      .axis_tvalid_o (axis_tvalid_o),
      .axis_tdata_o  (axis_tdata_o),
      .axis_tlast_o  (axis_tlast_o)
   );

endmodule

`default_nettype wire

// File: testbench/tb_axis_out.sv
// --------------------
// axis_out testbench driving the register bus and dma
// input and checking the byte stream against a reference model
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_axis_out;

   localparam int SCEN_BYTES  = 36;
   localparam int SCENARIOS   = 6;
   localparam int CYCLE_LIMIT = 40 * SCEN_BYTES * SCENARIOS;

   logic                              clk_i;
   logic                              reset_i;
   logic                              csr_we_i;
   logic [axis_out_pkg::ADDR_W-1:0]   csr_addr_i;
   logic [axis_out_pkg::DATA_W-1:0]   csr_wdata_i;
   logic [axis_out_pkg::DATA_W-1:0]   csr_rdata_o;
   logic                              csr_ready_o;
   logic                              sys_tvalid_i;
   logic [axis_out_pkg::DATA_W-1:0]   sys_tdata_i;
   logic                              sys_tready_o;
   logic                              axis_tvalid_o;
   logic [axis_out_pkg::TDATA_W-1:0]  axis_tdata_o;
   logic                              axis_tlast_o;
   logic                              axis_tready_i = 1'b0;
   logic                              interrupt_o;

   // reference bytes in stream order with rd_idx on the next one due
   logic [axis_out_pkg::TDATA_W-1:0]  exp_data [256];
   logic                              exp_last [256];
   int                                exp_cnt;
   int                                rd_idx;
   int                                xfer_len;
   int                                xfer_bytes;
   logic [axis_out_pkg::TDATA_W-1:0]  exp_byte;
   logic                              exp_lastb;
   logic                              exp_avail;

   // register state as the testbench expects it
   logic                              tb_enable;
   logic                              tb_dma;
   logic [axis_out_pkg::LEVEL_W-1:0]  tb_threshold;
   logic                              in_srst;

   int                                ready_mode;
   integer                            seed = 32'hfc67_b0d4;
   logic [31:0]                       rnd;
   int                                cycle_count = 0;
   int                                stream_errs = 0;
   int                                status_errs = 0;

   axis_out_top i_dut (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .csr_we_i      (csr_we_i),
      .csr_addr_i    (csr_addr_i),
      .csr_wdata_i   (csr_wdata_i),
      .csr_rdata_o   (csr_rdata_o),
      .csr_ready_o   (csr_ready_o),
      .sys_tvalid_i  (sys_tvalid_i),
      .sys_tdata_i   (sys_tdata_i),
      .sys_tready_o  (sys_tready_o),
      .axis_tvalid_o (axis_tvalid_o),
      .axis_tdata_o  (axis_tdata_o),
      .axis_tlast_o  (axis_tlast_o),
      .axis_tready_i (axis_tready_i),
      .interrupt_o   (interrupt_o)
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #10 clk_i = ~clk_i;
      end
   end

   // ready_mode picks low, high or random consumer ready
   always @(negedge clk_i) begin
      if (ready_mode == 2) begin
         rnd = $random(seed);
         axis_tready_i = rnd[0];
      end else begin
         axis_tready_i = (ready_mode == 1);
      end
   end

   // advance through the reference on every accepted byte
   always @(posedge clk_i) begin
      if (reset_i) begin
         rd_idx <= 0;
      end else if (in_srst) begin
         rd_idx <= exp_cnt;
      end else if (axis_tvalid_o && axis_tready_i) begin
         rd_idx <= rd_idx + 1;
      end
   end

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("stream errors: %0d, status errors: %0d", stream_errs, status_errs);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   assign exp_avail = (rd_idx < exp_cnt);
   assign exp_byte  = exp_data[rd_idx];
   assign exp_lastb = exp_last[rd_idx];

   a_byte_expected: assert property (
      @(posedge clk_i) disable iff (reset_i || in_srst)
      axis_tvalid_o |-> exp_avail
   ) else begin
      stream_errs++;
      $display("valid byte 0x%02h shown when no byte was expected", $sampled(axis_tdata_o));
   end

   a_tdata: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (axis_tvalid_o && axis_tready_i && exp_avail) |-> (axis_tdata_o == exp_byte)
   ) else begin
      stream_errs++;
      $display("FAILED axis_tdata_o: got 0x%02h, expected 0x%02h",
               $sampled(axis_tdata_o), $sampled(exp_byte));
   end

   a_tlast: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (axis_tvalid_o && axis_tready_i && exp_avail) |-> (axis_tlast_o == exp_lastb)
   ) else begin
      stream_errs++;
      $display("FAILED axis_tlast_o: got 0x%0h, expected 0x%0h",
               $sampled(axis_tlast_o), $sampled(exp_lastb));
   end

   a_hold: assert property (
      @(posedge clk_i) disable iff (reset_i || in_srst)
      (axis_tvalid_o && !axis_tready_i) |=>
         (axis_tvalid_o && $stable(axis_tdata_o) && $stable(axis_tlast_o))
   ) else begin
      stream_errs++;
      $display("stalled stream byte did not hold while ready was low");
   end

   a_sys_tready: assert property (
      @(posedge clk_i) disable iff (reset_i)
      sys_tready_o |-> (tb_enable && tb_dma)
   ) else begin
      status_errs++;
      $display("FAILED sys_tready_o: got 0x%0h, expected 0x0", $sampled(sys_tready_o));
   end

   a_disabled: assert property (
      @(posedge clk_i) disable iff (reset_i)
      !tb_enable |-> (!axis_tvalid_o && !sys_tready_o)
   ) else begin
      stream_errs++;
      $display("stream or dma handshake active while disabled");
   end

   a_interrupt: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (csr_addr_i == axis_out_pkg::ADDR_STATUS) |-> (interrupt_o ==
         (csr_rdata_o[axis_out_pkg::STATUS_LEVEL_LSB +: axis_out_pkg::LEVEL_W] <= tb_threshold))
   ) else begin
      status_errs++;
      $display("FAILED interrupt_o: got 0x%0h with level 0x%0h, threshold 0x%0h",
               $sampled(interrupt_o),
               $sampled(csr_rdata_o[axis_out_pkg::STATUS_LEVEL_LSB +: axis_out_pkg::LEVEL_W]),
               $sampled(tb_threshold));
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         status_errs++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // distinct bytes per lane so order mistakes show up
   function automatic logic [31:0] make_word(input int n);
      logic [7:0] b;
      b = 8'(4 * n);
      return {b + 8'd3, b + 8'd2, b + 8'd1, b} ^ 32'h5a3c_96e1;
   endfunction

   // split into lanes and keep only bytes inside the transfer
   task automatic queue_word(input logic [31:0] w);
      for (int i = 0; i < axis_out_pkg::LANES; i++) begin
         xfer_bytes++;
         if (xfer_bytes <= xfer_len) begin
            exp_data[exp_cnt] = w[i*axis_out_pkg::TDATA_W +: axis_out_pkg::TDATA_W];
            exp_last[exp_cnt] = (xfer_bytes == xfer_len);
            exp_cnt++;
         end
      end
   endtask

   task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
      @(negedge clk_i);
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(negedge clk_i);
      csr_we_i    = 1'b0;
      csr_addr_i  = axis_out_pkg::ADDR_STATUS;
      if (addr == axis_out_pkg::ADDR_CTRL) begin
         tb_enable = data[axis_out_pkg::CTRL_ENABLE_BIT];
         tb_dma    = data[axis_out_pkg::CTRL_MODE_BIT];
      end else if (addr == axis_out_pkg::ADDR_THRESHOLD) begin
         tb_threshold = data[axis_out_pkg::LEVEL_W-1:0];
      end
   endtask

   // address rests on the status register between writes
   task automatic read_status(output logic [31:0] st);
      @(negedge clk_i);
      st = csr_rdata_o;
   endtask

   task automatic cpu_word(input logic [31:0] w);
      queue_word(w);
      csr_write(axis_out_pkg::ADDR_DATA, w);
   endtask

   task automatic dma_word(input logic [31:0] w);
      @(negedge clk_i);
      while (!sys_tready_o) begin
         @(negedge clk_i);
      end
      sys_tvalid_i = 1'b1;
      sys_tdata_i  = w;
      queue_word(w);
      @(negedge clk_i);
      sys_tvalid_i = 1'b0;
   endtask

   // soft reset and then program the byte count
   task automatic new_transfer(input logic en, input logic dma, input int len);
      in_srst = 1'b1;
      csr_write(axis_out_pkg::ADDR_CTRL, {29'd0, 1'b1, dma, en});
      repeat (2) @(negedge clk_i);
      in_srst = 1'b0;
      csr_write(axis_out_pkg::ADDR_NWORDS, len);
      xfer_len   = len;
      xfer_bytes = 0;
   endtask

   // all expected bytes taken and padding popped
   task automatic wait_drained();
      logic [31:0] st;
      while (rd_idx < exp_cnt) begin
         @(negedge clk_i);
      end
      st = '0;
      while (!st[axis_out_pkg::STATUS_EMPTY_BIT]) begin
         read_status(st);
      end
   endtask

   initial begin
      logic [31:0] st;
      int          base;
      reset_i      = 1'b1;
      csr_we_i     = 1'b0;
      csr_addr_i   = axis_out_pkg::ADDR_STATUS;
      csr_wdata_i  = '0;
      sys_tvalid_i = 1'b0;
      sys_tdata_i  = '0;
      tb_enable    = 1'b0;
      tb_dma       = 1'b0;
      tb_threshold = '0;
      in_srst      = 1'b0;
      ready_mode   = 0;
      exp_cnt      = 0;
      xfer_len     = 0;
      xfer_bytes   = 0;
      repeat (4) @(negedge clk_i);
      check_value("axis_tvalid_o", axis_tvalid_o, 0);
      check_value("axis_tlast_o", axis_tlast_o, 0);
      check_value("sys_tready_o", sys_tready_o, 0);
      check_value("interrupt_o", interrupt_o, 1);
      reset_i = 1'b0;

      // processor mode with two padding bytes at the end
      new_transfer(1'b1, 1'b0, 10);
      ready_mode = 2;
      for (int i = 0; i < 3; i++) begin
         cpu_word(make_word(i));
      end
      wait_drained();

      // dma mode
      new_transfer(1'b1, 1'b1, 16);
      for (int i = 0; i < 4; i++) begin
         dma_word(make_word(10 + i));
      end
      wait_drained();

      // fill under back-pressure and write once too many
      ready_mode = 0;
      new_transfer(1'b1, 1'b0, 36);
      for (int i = 0; i < 8; i++) begin
         check_value("csr_ready_o", csr_ready_o, 1);
         cpu_word(make_word(20 + i));
      end
      read_status(st);
      check_value("status full", st[axis_out_pkg::STATUS_FULL_BIT], 1);
      check_value("status level", st[axis_out_pkg::STATUS_LEVEL_LSB +: 6], 31);
      check_value("csr_ready_o", csr_ready_o, 0);
      csr_write(axis_out_pkg::ADDR_DATA, 32'hdead_beef);
      read_status(st);
      check_value("status level", st[axis_out_pkg::STATUS_LEVEL_LSB +: 6], 31);
      // dma mode while full, no soft reset
      csr_write(axis_out_pkg::ADDR_CTRL, 32'd3);
      check_value("sys_tready_o", sys_tready_o, 0);
      csr_write(axis_out_pkg::ADDR_CTRL, 32'd1);
      ready_mode = 2;
      wait_drained();
      // bytes 33 to 36 come from this word and not the dropped one
      cpu_word(make_word(28));
      wait_drained();

      // interrupt against threshold 4
      ready_mode = 0;
      new_transfer(1'b1, 1'b0, 16);
      csr_write(axis_out_pkg::ADDR_THRESHOLD, 4);
      for (int i = 0; i < 4; i++) begin
         cpu_word(make_word(30 + i));
      end
      read_status(st);
      check_value("status level", st[axis_out_pkg::STATUS_LEVEL_LSB +: 6], 15);
      check_value("interrupt_o", interrupt_o, 0);
      ready_mode = 2;
      wait_drained();
      check_value("interrupt_o", interrupt_o, 1);

      // nothing gets in while disabled
      new_transfer(1'b0, 1'b1, 8);
      @(negedge clk_i);
      sys_tvalid_i = 1'b1;
      sys_tdata_i  = make_word(40);
      repeat (4) @(negedge clk_i);
      sys_tvalid_i = 1'b0;
      csr_write(axis_out_pkg::ADDR_CTRL, 0);
      csr_write(axis_out_pkg::ADDR_DATA, make_word(41));
      csr_write(axis_out_pkg::ADDR_DATA, make_word(42));
      read_status(st);
      check_value("status level", st[axis_out_pkg::STATUS_LEVEL_LSB +: 6], 0);
      check_value("status empty", st[axis_out_pkg::STATUS_EMPTY_BIT], 1);
      check_value("axis_tvalid_o", axis_tvalid_o, 0);

      // soft reset with a byte stalled mid-transfer
      new_transfer(1'b1, 1'b0, 12);
      ready_mode = 2;
      base = exp_cnt;
      for (int i = 0; i < 3; i++) begin
         cpu_word(make_word(50 + i));
      end
      while (rd_idx < base + 5) begin
         @(negedge clk_i);
      end
      ready_mode = 0;
      repeat (2) @(negedge clk_i);
      check_value("axis_tvalid_o", axis_tvalid_o, 1);
      new_transfer(1'b1, 1'b0, 6);
      read_status(st);
      check_value("status empty", st[axis_out_pkg::STATUS_EMPTY_BIT], 1);
      check_value("status level", st[axis_out_pkg::STATUS_LEVEL_LSB +: 6], 0);
      check_value("axis_tvalid_o", axis_tvalid_o, 0);
      ready_mode = 2;
      for (int i = 0; i < 2; i++) begin
         cpu_word(make_word(60 + i));
      end
      wait_drained();

      $display("stream errors: %0d, status errors: %0d", stream_errs, status_errs);
      if (stream_errs == 0 && status_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
source/axis_out_pkg.sv
source/axis_out_csr.sv
source/axis_out_fifo.sv
source/axis_out_serializer.sv
source/axis_out_top.sv
testbench/tb_axis_out.sv

// File: Bender.yml
package:
  name: axis_out

sources:
  - source/axis_out_pkg.sv
  - source/axis_out_csr.sv
  - source/axis_out_fifo.sv
  - source/axis_out_serializer.sv
  - source/axis_out_top.sv
  - target: test
    files:
      - testbench/tb_axis_out.sv
